// File: Bender.yml
package:
  name: if_stage

sources:
  - common/if_pkg.sv
  - fetch/if_pc_select.sv
  - fetch/if_fetch_unit.sv
  - src/if_compressed_decoder.sv
  - src/if_id_register.sv
  - src/if_stage_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_if_stage.sv

// File: common/if_pkg.sv
// Shared types and constants for the instruction fetch stage, referenced by scoped name
package if_pkg;

  //////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////

  // Byte address on the instruction side
  typedef logic [31:0] addr_t;
  // Full 32-bit instruction word
  typedef logic [31:0] instr_t;
  // Compressed instruction halfword
  typedef logic [15:0] cinstr_t;
  // Trap vector base, bits 31 down to 7
  typedef logic [24:0] mtvec_addr_t;
  // Interrupt index for vectored mode
  typedef logic [4:0]  irq_id_t;

  // Word alignment of the boot address
  localparam int unsigned INSTR_ALIGN_BITS = 2;
  // Trap base sits above this bit
  localparam int unsigned MTVEC_LSB = 7;

  // Major opcodes produced by the expander
  localparam logic [6:0] OPCODE_ADDI = 7'h13;
  localparam logic [6:0] OPCODE_OP   = 7'h33;

  // addi x0, x0, 0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Redirect source selected by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Fetch FSM, one outstanding request at most
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    WAIT_RESP = 2'd1,
    HOLD      = 2'd2
  } fetch_state_e;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // Controller request into IF
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    irq_id_t irq_id;
    logic    halt_if;
  } ctrl_fsm_t;

  // Word returned by the fetch unit
  typedef struct packed {
    addr_t  pc;
    instr_t rdata;
    logic   bus_err;
  } fetch_word_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic    instr_valid;
    addr_t   pc;
    instr_t  instr;
    logic    compressed;
    logic    illegal_c_insn;
    logic    bus_err;
    cinstr_t compressed_instr;
  } if_id_pipe_t;

endpackage

// File: fetch/if_fetch_unit.sv
// Instruction memory requester with one outstanding fetch and a single word hold buffer
module if_fetch_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                redirect_i,
  input  if_pkg::addr_t       fetch_pc_i,
  input  logic                consume_i,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic                instr_err_i,
  input  if_pkg::instr_t      instr_rdata_i,
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  output logic                word_valid_o,
  output if_pkg::fetch_word_t word_o,
  output logic                busy_o
);

  if_pkg::fetch_state_e state_q, state_n;
  logic                 want_q, want_n;
  logic                 drop_q, drop_n;
  logic                 lock_q;
  if_pkg::addr_t        addr_q;
  if_pkg::fetch_word_t  word_q;
  logic                 req_gnt;
  logic                 resp_keep;

  // Word aligned request, pinned while a redirect waits behind a pending request
  assign instr_addr_o = lock_q ? addr_q : {fetch_pc_i[31:2], 2'b00};
  assign instr_req_o  = (state_q == if_pkg::IDLE) && want_q;
  assign req_gnt      = instr_req_o && instr_gnt_i;
  // Response is kept unless stale or overtaken in the same cycle
  assign resp_keep    = (state_q == if_pkg::WAIT_RESP) && instr_rvalid_i &&
                        !drop_q && !redirect_i;

  //////////////////////////////////////////////////
  // FSM next state
  //////////////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    want_n  = want_q;
    drop_n  = drop_q;
    unique case (state_q)
      if_pkg::IDLE: begin
        if (req_gnt) state_n = if_pkg::WAIT_RESP;
      end
      if_pkg::WAIT_RESP: begin
        if (instr_rvalid_i) state_n = resp_keep ? if_pkg::HOLD : if_pkg::IDLE;
      end
      if_pkg::HOLD: begin
        if (consume_i || redirect_i) state_n = if_pkg::IDLE;
      end
      default: state_n = if_pkg::IDLE;
    endcase
    // A granted stale request still needs a refetch
    if (req_gnt) want_n = drop_q;
    if ((state_q == if_pkg::HOLD) && consume_i) want_n = 1'b1;
    if (redirect_i) want_n = 1'b1;
    // Stale response retired
    if ((state_q == if_pkg::WAIT_RESP) && instr_rvalid_i) drop_n = 1'b0;
    // Redirect behind an issued or pending request
    if (redirect_i && (instr_req_o ||
        ((state_q == if_pkg::WAIT_RESP) && !instr_rvalid_i))) begin
      drop_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= if_pkg::IDLE;
      want_q  <= 1'b0;
      drop_q  <= 1'b0;
      lock_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      want_q  <= want_n;
      drop_q  <= drop_n;
      // Pin the address until the grant
      if (req_gnt) begin
        lock_q <= 1'b0;
      end else if (instr_req_o && redirect_i) begin
        lock_q <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (instr_req_o && !instr_gnt_i && redirect_i && !lock_q) begin
      addr_q <= instr_addr_o;
    end
    if (resp_keep) begin
      word_q.pc      <= fetch_pc_i;
      word_q.rdata   <= instr_rdata_i;
      word_q.bus_err <= instr_err_i;
    end
  end

  assign word_o       = word_q;
  assign word_valid_o = (state_q == if_pkg::HOLD);
  assign busy_o       = (state_q == if_pkg::WAIT_RESP);

  // No response without a granted request
  a_rvalid_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (state_q == if_pkg::WAIT_RESP));

  // Request and address hold until granted
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)));

endmodule

// File: fetch/if_pc_select.sv
// Redirect target decode and fetch PC register, advanced by the consumed instruction length
module if_pc_select (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  if_pkg::addr_t       boot_addr_i,
  input  if_pkg::addr_t       jump_target_i,
  input  if_pkg::addr_t       branch_target_i,
  input  if_pkg::addr_t       mepc_i,
  input  if_pkg::mtvec_addr_t mtvec_addr_i,
  input  logic                consume_i,
  input  logic                instr_len4_i,
  output logic                redirect_o,
  output if_pkg::addr_t       fetch_pc_o,
  output logic                csr_mtvec_init_o
);

  if_pkg::addr_t target;
  if_pkg::addr_t pc_incr;
  if_pkg::addr_t fetch_pc_q;

  //////////////////////////////////////////////////
  // Target selection
  //////////////////////////////////////////////////

  always_comb begin
    // Boot address by default
    target = {boot_addr_i[31:if_pkg::INSTR_ALIGN_BITS], {if_pkg::INSTR_ALIGN_BITS{1'b0}}};
    unique case (ctrl_fsm_i.pc_mux)
      if_pkg::PC_BOOT:     target = {boot_addr_i[31:if_pkg::INSTR_ALIGN_BITS],
                                     {if_pkg::INSTR_ALIGN_BITS{1'b0}}};
      if_pkg::PC_JUMP:     target = jump_target_i;
      if_pkg::PC_BRANCH:   target = branch_target_i;
      // Return from trap
      if_pkg::PC_MRET:     target = mepc_i;
      // All exceptions share the base
      if_pkg::PC_TRAP_EXC: target = {mtvec_addr_i, {if_pkg::MTVEC_LSB{1'b0}}};
      // Vectored interrupts, one word per index
      if_pkg::PC_TRAP_IRQ: target = {mtvec_addr_i, ctrl_fsm_i.irq_id,
                                     {if_pkg::INSTR_ALIGN_BITS{1'b0}}};
      default: ;
    endcase
  end

  // Step size of the consumed instruction
  assign pc_incr = instr_len4_i ? 32'd4 : 32'd2;

  //////////////////////////////////////////////////
  // Fetch PC
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_pc_q <= '0;
    end else if (ctrl_fsm_i.pc_set) begin
      // Redirect wins over sequential advance
      fetch_pc_q <= target;
    end else if (consume_i) begin
      fetch_pc_q <= fetch_pc_q + pc_incr;
    end
  end

  assign fetch_pc_o = fetch_pc_q;
  assign redirect_o = ctrl_fsm_i.pc_set;

  // CSR file initialises mtvec on boot
  assign csr_mtvec_init_o = ctrl_fsm_i.pc_set && (ctrl_fsm_i.pc_mux == if_pkg::PC_BOOT);

  // Controller only requests known redirect sources
  a_pc_mux_known: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_fsm_i.pc_set |-> ctrl_fsm_i.pc_mux inside {if_pkg::PC_BOOT, if_pkg::PC_JUMP,
      if_pkg::PC_BRANCH, if_pkg::PC_MRET, if_pkg::PC_TRAP_EXC, if_pkg::PC_TRAP_IRQ});

endmodule

// File: if_stage.f
+incdir+sim
common/if_pkg.sv
fetch/if_pc_select.sv
fetch/if_fetch_unit.sv
src/if_compressed_decoder.sv
src/if_id_register.sv
src/if_stage_top.sv
sim/tb_if_stage.sv

// File: sim/tb_if_model.svh
// Testbench model helpers included into the testbench top: LCG, memory rule, expansion, compares
`ifndef TB_IF_MODEL_SVH
`define TB_IF_MODEL_SVH

//////////////////////////////////////////////////
// Random source and memory contents
//////////////////////////////////////////////////

// Numerical Recipes LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// Halfword biased toward the four expanded encodings
function automatic if_pkg::cinstr_t shape_half(input logic [31:0] r);
  if_pkg::cinstr_t h;
  h = r[31:16];
  case (r[15:13])
    3'd0: h = {3'b000, h[12:2], 2'b01};
    3'd1: h = {3'b010, h[12:2], 2'b01};
    // C.MV with rs2 forced nonzero
    3'd2: h = {4'b1000, h[11:7], h[6:3], 1'b1, 2'b10};
    // C.ADD, rs2 may be zero and thus illegal
    3'd3: h = {4'b1001, h[11:7], h[6:2], 2'b10};
    3'd4, 3'd5: h[1:0] = 2'b11;
    default: ;
  endcase
  return h;
endfunction

// Word content is a hash of the word address
function automatic if_pkg::instr_t mem_word(input if_pkg::addr_t a);
  logic [31:0] h1;
  logic [31:0] h2;
  h1 = lcg_next({a[31:2], 2'b00} ^ 32'h2545_f491);
  h2 = lcg_next(h1);
  return {shape_half(h2), shape_half(h1)};
endfunction

// About one word in sixteen answers with a bus error
function automatic logic mem_err(input if_pkg::addr_t a);
  logic [31:0] h;
  h = lcg_next(lcg_next({a[31:2], 2'b00} ^ 32'h5bd1_e995));
  return (h[31:28] == 4'h0);
endfunction

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Expected IF/ID content for an instruction fetched at pc
function automatic if_pkg::if_id_pipe_t expect_load(input if_pkg::addr_t pc,
                                                   input if_pkg::cinstr_t last_c);
  if_pkg::if_id_pipe_t e;
  if_pkg::instr_t      w;
  if_pkg::cinstr_t     h;
  logic [31:0]         rd;
  logic [31:0]         rs2;
  logic [31:0]         simm;
  w    = mem_word(pc);
  h    = pc[1] ? w[31:16] : w[15:0];
  rd   = {27'd0, h[11:7]};
  rs2  = {27'd0, h[6:2]};
  simm = {{26{h[12]}}, h[12], h[6:2]};
  e.instr_valid      = 1'b1;
  e.pc               = pc;
  e.bus_err          = mem_err(pc);
  e.compressed       = (h[1:0] != 2'b11);
  e.compressed_instr = e.compressed ? h : last_c;
  // Forms outside the subset pass through zero extended
  e.instr            = {16'd0, h};
  e.illegal_c_insn   = 1'b1;
  if (!e.compressed) begin
    e.instr          = w;
    e.illegal_c_insn = pc[1];
  end else if (h[1:0] == 2'b01 && (h[15:13] == 3'b000 || h[15:13] == 3'b010)) begin
    // addi with rs1 = rd for C.ADDI, x0 for C.LI
    e.instr          = (simm << 20) | (h[14] ? 32'd0 : rd << 15) | (rd << 7) | 32'h13;
    e.illegal_c_insn = 1'b0;
  end else if (h[1:0] == 2'b10 && h[15:13] == 3'b100 && rs2 != 0) begin
    // add with rs1 = rd for C.ADD, x0 for C.MV
    e.instr          = (rs2 << 20) | (h[12] ? rd << 15 : 32'd0) | (rd << 7) | 32'h33;
    e.illegal_c_insn = 1'b0;
  end
  return e;
endfunction

// Next fetch address for a redirect request
function automatic if_pkg::addr_t redirect_target(input if_pkg::ctrl_fsm_t c,
                                                  input if_pkg::addr_t boot, jump, branch, mepc,
                                                  input if_pkg::mtvec_addr_t mtvec);
  if_pkg::addr_t base;
  base = {7'd0, mtvec} << 7;
  case (c.pc_mux)
    if_pkg::PC_BOOT:     return boot & ~32'd3;
    if_pkg::PC_JUMP:     return jump;
    if_pkg::PC_BRANCH:   return branch;
    if_pkg::PC_MRET:     return mepc;
    if_pkg::PC_TRAP_EXC: return base;
    default:             return base | ({27'd0, c.irq_id} << 2);
  endcase
endfunction

//////////////////////////////////////////////////
// Compares
//////////////////////////////////////////////////

task automatic check_pipe(input string name, input if_pkg::if_id_pipe_t exp,
                          input if_pkg::if_id_pipe_t act);
  if (act !== exp) begin
    stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  end
endtask

task automatic check_addr(input string name, input if_pkg::addr_t exp,
                          input if_pkg::addr_t act);
  if (act !== exp) begin
    stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    stop_on_error($sformatf("mismatch %s expected %b actual %b", name, exp, act));
  end
endtask

`endif

// File: sim/tb_if_stage.sv
// Self-checking testbench for the fetch stage, random memory timing and a PC sequence model
module tb_if_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NUM_LOADS  = 600;
  localparam int unsigned IDLE_LIMIT = 200;

  logic                clk;
  logic                rst_n;
  if_pkg::ctrl_fsm_t   ctrl_fsm_i;
  if_pkg::addr_t       boot_addr_i, jump_target_i, branch_target_i, mepc_i;
  if_pkg::mtvec_addr_t mtvec_addr_i;
  logic                id_ready_i;
  logic                instr_gnt_i, instr_rvalid_i, instr_err_i;
  if_pkg::instr_t      instr_rdata_i;
  logic                instr_req_o, if_valid_o, csr_mtvec_init_o, if_busy_o;
  if_pkg::addr_t       instr_addr_o, pc_if_o;
  if_pkg::if_id_pipe_t if_id_pipe_o;

  // Values for the next cycle, applied on the rising edge
  if_pkg::ctrl_fsm_t   ctrl_nx;
  if_pkg::addr_t       boot_nx, jump_nx, branch_nx, mepc_nx;
  if_pkg::mtvec_addr_t mtvec_nx;
  logic                ready_nx, gnt_nx, rvalid_nx, err_nx;
  if_pkg::instr_t      rdata_nx;

  // Model state
  logic [31:0]         seed;
  if_pkg::addr_t       model_pc, resp_addr, req_addr;
  if_pkg::cinstr_t     last_c;
  if_pkg::if_id_pipe_t exp_pipe, held_pipe;
  logic                load_pend, stall_pend, outstanding, req_seen;
  logic                seen [6];
  int unsigned         loads, idle, halt_left, gnt_wait, resp_wait, missing;

  if_stage_top dut (.*);

  always #5ns clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped on the first error");
  endtask

  `include "tb_if_model.svh"

  function automatic logic [31:0] rand_word();
    seed = lcg_next(seed);
    return seed;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = rand_word();
    return r[31:16] % n;
  endfunction

  //////////////////////////////////////////////////
  // Per cycle checking at the falling edge
  //////////////////////////////////////////////////

  task automatic observe();
    idle++;
    if (load_pend) begin
      check_pipe("load", exp_pipe, if_id_pipe_o);
      load_pend = 1'b0;
      loads++;
      idle = 0;
    end
    // Decode stalled last cycle
    if (stall_pend) begin
      check_pipe("stall_hold", held_pipe, if_id_pipe_o);
    end
    stall_pend = 1'b0;
    check_addr("pc_track", model_pc, pc_if_o);
    // Fresh request starts at the model PC, a waiting one keeps its address
    if (instr_req_o) begin
      if (!req_seen) begin
        check_addr("req_addr", {model_pc[31:2], 2'b00}, instr_addr_o);
      end else begin
        check_addr("req_hold", req_addr, instr_addr_o);
      end
      req_addr = instr_addr_o;
    end
    check_bit("mtvec_init", ctrl_fsm_i.pc_set && (ctrl_fsm_i.pc_mux == if_pkg::PC_BOOT),
              csr_mtvec_init_o);
    if (ctrl_fsm_i.halt_if) begin
      check_bit("halt", 1'b0, if_valid_o);
    end
    // Handshake, the register loads at the coming edge
    if (if_valid_o && id_ready_i) begin
      exp_pipe  = expect_load(model_pc, last_c);
      last_c    = exp_pipe.compressed_instr;
      model_pc  = model_pc + (exp_pipe.compressed ? 32'd2 : 32'd4);
      load_pend = 1'b1;
    end
    if (!id_ready_i) begin
      held_pipe  = if_id_pipe_o;
      stall_pend = 1'b1;
    end
    // Redirect overrides the sequential step
    if (ctrl_fsm_i.pc_set) begin
      model_pc = redirect_target(ctrl_fsm_i, boot_addr_i, jump_target_i, branch_target_i,
                                 mepc_i, mtvec_addr_i);
      seen[ctrl_fsm_i.pc_mux] = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // Memory responder
  //////////////////////////////////////////////////

  task automatic respond();
    gnt_nx    = 1'b0;
    rvalid_nx = 1'b0;
    rdata_nx  = '0;
    err_nx    = 1'b0;
    // Busy spans the granted request up to its response
    check_bit("busy", outstanding, if_busy_o);
    if (instr_req_o && outstanding) begin
      stop_on_error("request issued while a response is still outstanding");
    end
    if (instr_gnt_i && instr_req_o) begin
      // Grant taken at the coming edge
      outstanding = 1'b1;
      resp_addr   = instr_addr_o;
      resp_wait   = 1 + rand_below(4);
      req_seen    = 1'b0;
    end else if (instr_req_o) begin
      if (!req_seen) begin
        req_seen = 1'b1;
        gnt_wait = rand_below(4);
      end
      if (gnt_wait == 0) begin
        gnt_nx = 1'b1;
      end else begin
        gnt_wait--;
      end
    end
    if (outstanding && instr_rvalid_i) begin
      outstanding = 1'b0;
    end else if (outstanding) begin
      resp_wait--;
      if (resp_wait == 0) begin
        rvalid_nx = 1'b1;
        rdata_nx  = mem_word(resp_addr);
        err_nx    = mem_err(resp_addr);
      end
    end
  endtask

  task automatic plan_stimulus();
    ready_nx        = (rand_below(4) != 0);
    ctrl_nx.pc_set  = 1'b0;
    ctrl_nx.halt_if = (halt_left != 0);
    if (halt_left != 0) begin
      halt_left--;
    end else if (rand_below(40) == 0) begin
      halt_left = 1 + rand_below(12);
    end
    if (rand_below(20) == 0) begin
      ctrl_nx.pc_set = 1'b1;
      ctrl_nx.pc_mux = if_pkg::pc_mux_e'(rand_below(6));
      ctrl_nx.irq_id = if_pkg::irq_id_t'(rand_below(32));
      boot_nx        = rand_word();
      // Halfword aligned targets
      jump_nx        = rand_word() & ~32'd1;
      branch_nx      = rand_word() & ~32'd1;
      mepc_nx        = rand_word() & ~32'd1;
      mtvec_nx       = if_pkg::mtvec_addr_t'(rand_word());
    end
  endtask

  task automatic tick();
    @(posedge clk);
    rst_n           <= 1'b1;
    ctrl_fsm_i      <= ctrl_nx;
    boot_addr_i     <= boot_nx;
    jump_target_i   <= jump_nx;
    branch_target_i <= branch_nx;
    mepc_i          <= mepc_nx;
    mtvec_addr_i    <= mtvec_nx;
    id_ready_i      <= ready_nx;
    instr_gnt_i     <= gnt_nx;
    instr_rvalid_i  <= rvalid_nx;
    instr_rdata_i   <= rdata_nx;
    instr_err_i     <= err_nx;
    @(negedge clk);
    observe();
    respond();
    plan_stimulus();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    ctrl_fsm_i = '0;
    boot_addr_i = '0;
    jump_target_i = '0;
    branch_target_i = '0;
    mepc_i = '0;
    mtvec_addr_i = '0;
    id_ready_i = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    seed = 32'd20;
    model_pc = '0;
    req_addr = '0;
    last_c = '0;
    load_pend = 1'b0;
    stall_pend = 1'b0;
    outstanding = 1'b0;
    req_seen = 1'b0;
    loads = 0;
    idle = 0;
    halt_left = 0;
    foreach (seen[i]) seen[i] = 1'b0;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check_bit("reset", 1'b0, instr_req_o);
      check_bit("reset", 1'b0, if_valid_o);
      check_bit("reset", 1'b0, if_busy_o);
      check_bit("reset", 1'b0, if_id_pipe_o.instr_valid);
    end
    // Boot request in the first cycle out of reset
    ctrl_nx = '0;
    ctrl_nx.pc_set = 1'b1;
    ctrl_nx.pc_mux = if_pkg::PC_BOOT;
    boot_nx = rand_word();
    jump_nx = '0;
    branch_nx = '0;
    mepc_nx = '0;
    mtvec_nx = '0;
    ready_nx = 1'b1;
    gnt_nx = 1'b0;
    rvalid_nx = 1'b0;
    rdata_nx = '0;
    err_nx = 1'b0;
    tick();
    check_bit("after_reset", 1'b0, instr_req_o);
    check_bit("after_reset", 1'b0, if_valid_o);
    check_bit("after_reset", 1'b0, if_busy_o);
    check_bit("after_reset", 1'b0, if_id_pipe_o.instr_valid);
    while (loads < NUM_LOADS) begin
      tick();
      if (idle > IDLE_LIMIT) begin
        stop_on_error($sformatf("timeout, no instruction loaded within %0d cycles",
                                IDLE_LIMIT));
      end
    end
    missing = 0;
    foreach (seen[i]) begin
      if (!seen[i]) missing++;
    end
    if (missing == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d redirect sources were never exercised", missing));
    end
  end

endmodule

// File: src/if_compressed_decoder.sv
// Halfword selection by PC and expansion of the supported compressed instructions
module if_compressed_decoder (
  input  if_pkg::fetch_word_t word_i,
  output if_pkg::instr_t      instr_o,
  output logic                compressed_o,
  output logic                illegal_c_o,
  output if_pkg::cinstr_t     cinstr_o
);

  if_pkg::cinstr_t hw;
  logic [4:0]      rd;
  logic [4:0]      rs2;
  logic [2:0]      funct3;
  logic [11:0]     imm;
  logic            is32;

  // Upper half for PC bit 1
  assign hw     = word_i.pc[1] ? word_i.rdata[31:16] : word_i.rdata[15:0];
  assign is32   = (hw[1:0] == 2'b11);
  assign funct3 = hw[15:13];
  assign rd     = hw[11:7];
  assign rs2    = hw[6:2];
  // 6-bit immediate from bits 12 and 6:2, sign extended
  assign imm    = {{6{hw[12]}}, hw[12], hw[6:2]};

  //////////////////////////////////////////////////
  // Expansion
  //////////////////////////////////////////////////

  always_comb begin
    // Unknown compressed form passes through zero extended
    instr_o     = {16'h0000, hw};
    illegal_c_o = 1'b1;
    if (is32) begin
      instr_o     = word_i.rdata;
      // Straddling words is not supported
      illegal_c_o = word_i.pc[1];
    end else begin
      unique case (hw[1:0])
        2'b01: begin
          if (funct3 == 3'b000) begin
            // C.ADDI
            instr_o     = {imm, rd, 3'b000, rd, if_pkg::OPCODE_ADDI};
            illegal_c_o = 1'b0;
          end else if (funct3 == 3'b010) begin
            // C.LI
            instr_o     = {imm, 5'd0, 3'b000, rd, if_pkg::OPCODE_ADDI};
            illegal_c_o = 1'b0;
          end
        end
        2'b10: begin
          if ((funct3 == 3'b100) && (rs2 != 5'd0)) begin
            if (hw[12]) begin
              // C.ADD
              instr_o = {7'b0000000, rs2, rd, 3'b000, rd, if_pkg::OPCODE_OP};
            end else begin
              // C.MV
              instr_o = {7'b0000000, rs2, 5'd0, 3'b000, rd, if_pkg::OPCODE_OP};
            end
            illegal_c_o = 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  assign compressed_o = !is32;
  assign cinstr_o     = hw;

endmodule

// File: src/if_id_register.sv
// IF/ID pipeline register, loaded on handshake and frozen while decode stalls
module if_id_register (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load_i,
  input  logic                id_ready_i,
  input  if_pkg::fetch_word_t word_i,
  input  if_pkg::instr_t      instr_i,
  input  logic                compressed_i,
  input  logic                illegal_c_i,
  input  if_pkg::cinstr_t     cinstr_i,
  output if_pkg::if_id_pipe_t if_id_pipe_o
);

  //////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o.instr_valid      <= 1'b0;
      if_id_pipe_o.pc               <= '0;
      if_id_pipe_o.instr            <= if_pkg::NOP_INSTR;
      if_id_pipe_o.compressed       <= 1'b0;
      if_id_pipe_o.illegal_c_insn   <= 1'b0;
      if_id_pipe_o.bus_err          <= 1'b0;
      if_id_pipe_o.compressed_instr <= '0;
    end else if (load_i) begin
      if_id_pipe_o.instr_valid    <= 1'b1;
      if_id_pipe_o.pc             <= word_i.pc;
      if_id_pipe_o.instr          <= instr_i;
      if_id_pipe_o.compressed     <= compressed_i;
      if_id_pipe_o.illegal_c_insn <= illegal_c_i;
      if_id_pipe_o.bus_err        <= word_i.bus_err;
      // Original halfword kept for compressed only
      if (compressed_i) begin
        if_id_pipe_o.compressed_instr <= cinstr_i;
      end
    end else if (id_ready_i) begin
      // Decode took it, nothing new behind
      if_id_pipe_o.instr_valid <= 1'b0;
    end
  end

  // Stalled decode sees a frozen instruction
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (if_id_pipe_o.instr_valid && !id_ready_i) |=> $stable(if_id_pipe_o));

endmodule

// File: src/if_stage_top.sv
// Instruction fetch stage top, wires PC select, fetch, expansion and the IF/ID register
module if_stage_top (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  if_pkg::addr_t       boot_addr_i,
  input  if_pkg::addr_t       jump_target_i,
  input  if_pkg::addr_t       branch_target_i,
  input  if_pkg::addr_t       mepc_i,
  input  if_pkg::mtvec_addr_t mtvec_addr_i,
  input  logic                id_ready_i,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::instr_t      instr_rdata_i,
  input  logic                instr_err_i,
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  output logic                if_valid_o,
  output if_pkg::if_id_pipe_t if_id_pipe_o,
  output if_pkg::addr_t       pc_if_o,
  output logic                csr_mtvec_init_o,
  output logic                if_busy_o
);

  logic                redirect;
  logic                consume;
  logic                word_valid;
  if_pkg::fetch_word_t word;
  if_pkg::instr_t      instr_exp;
  logic                compressed;
  logic                illegal_c;
  if_pkg::cinstr_t     cinstr;

  // Halt masks the word, handshake consumes it
  assign if_valid_o = word_valid && !ctrl_fsm_i.halt_if;
  assign consume    = if_valid_o && id_ready_i;

  if_pc_select u_pc_select (
    .clk, .rst_n, .ctrl_fsm_i, .boot_addr_i, .jump_target_i, .branch_target_i, .mepc_i,
    .mtvec_addr_i,
    .consume_i        (consume),
    .instr_len4_i     (!compressed),
    .redirect_o       (redirect),
    .fetch_pc_o       (pc_if_o),
    .csr_mtvec_init_o
  );

  if_fetch_unit u_fetch_unit (
    .clk, .rst_n,
    .redirect_i   (redirect),
    .fetch_pc_i   (pc_if_o),
    .consume_i    (consume),
    .instr_gnt_i, .instr_rvalid_i, .instr_err_i, .instr_rdata_i, .instr_req_o, .instr_addr_o,
    .word_valid_o (word_valid),
    .word_o       (word),
    .busy_o       (if_busy_o)
  );

  if_compressed_decoder u_c_decoder (
    .word_i (word), .instr_o (instr_exp), .compressed_o (compressed),
    .illegal_c_o (illegal_c), .cinstr_o (cinstr)
  );

  if_id_register u_if_id (
    .clk, .rst_n, .load_i (consume), .id_ready_i, .word_i (word), .instr_i (instr_exp),
    .compressed_i (compressed), .illegal_c_i (illegal_c), .cinstr_i (cinstr), .if_id_pipe_o
  );

endmodule
